//--- uart_rx_config.svh
`ifndef UART_RX_CONFIG_SVH
`define UART_RX_CONFIG_SVH

// -----------------------------------------------
// Input stage and bit timing
// -----------------------------------------------
`define UART_RX_SYNC_STAGES  2   // Flops between pin and logic
`define UART_RX_OS_WIDTH     5   // Oversample counter width
`define UART_RX_OS_LAST      15  // Counter wraps here, 16 ticks per bit
`define UART_RX_OS_CENTER    8   // Bit center count
`define UART_RX_OS_MAJ_INIT  5   // Majority filter cleared here

// -----------------------------------------------
// Receive FIFO
// -----------------------------------------------
`define UART_RX_FIFO_DEPTH   16
// Must hold 0 up to full depth
`define UART_RX_USAGE_WIDTH  5

// Character timeout in baud ticks
// 12 bit times of a longest frame, times 4
`define UART_RX_TIMEOUT_BAUDS 48

`endif

//--- uart_rx_pkg.sv
`default_nettype none

package uart_rx_pkg;

  // Frame FSM states
  typedef enum logic [2:0] {
    rx_idle   = 3'd0,
    rx_start  = 3'd1,
    rx_data   = 3'd2,
    rx_parity = 3'd3,
    rx_stop   = 3'd4,
    rx_resync = 3'd5  // After a framing error
  } rx_state_e;

  // One received character plus status, 11 bits
  typedef struct packed {
    logic       parity_err; // Parity mismatch for selected mode
    logic       frame_err;  // Stop bit sampled low
    logic       brk;        // Data, parity and stop all zero
    logic [7:0] data;       // LSB first, unused upper bits zero
  } rx_entry_t;

  typedef enum logic [1:0] {
    wl_5, wl_6, wl_7, wl_8
  } word_len_e;

  typedef enum logic [1:0] {
    par_odd, par_even, par_force_1, par_force_0
  } parity_mode_e;

  // FIFO trigger level in characters
  typedef enum logic [1:0] {
    tl_1, tl_4, tl_8, tl_14
  } fifo_tl_e;

endpackage

`default_nettype wire

//--- rx_bit_sampler.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_rx_config.svh"

module rx_bit_sampler (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic os_tick_i,       // 16x baud strobe
  input  logic rxd_i,           // Raw serial pin
  input  logic timer_restart_i, // Start edge seen by FSM
  output logic rxd_sync_o,
  output logic bit_center_o,
  output logic bit_value_o
);

  localparam logic [`UART_RX_OS_WIDTH-1:0] os_last     = `UART_RX_OS_LAST;
  localparam logic [`UART_RX_OS_WIDTH-1:0] os_center   = `UART_RX_OS_CENTER;
  localparam logic [`UART_RX_OS_WIDTH-1:0] os_maj_init = `UART_RX_OS_MAJ_INIT;

  logic [`UART_RX_SYNC_STAGES-1:0] sync_q;     // Shift chain, MSB is oldest
  logic [`UART_RX_OS_WIDTH-1:0]    os_cnt_q;   // Position inside current bit
  logic [1:0]                      high_cnt_q; // High samples before center
  logic                            in_window;

  // -----------------------------------------------
  // Synchronizer
  // -----------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q <= '1; // Idle line is high
    end else begin
      sync_q <= {sync_q[`UART_RX_SYNC_STAGES-2:0], rxd_i};
    end
  end

  assign rxd_sync_o = sync_q[`UART_RX_SYNC_STAGES-1];

  // -----------------------------------------------
  // Oversample bit timer
  // -----------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      os_cnt_q <= '0;
    end else if (timer_restart_i) begin
      os_cnt_q <= '0; // Align to start edge
    end else if (os_tick_i) begin
      os_cnt_q <= (os_cnt_q == os_last) ? '0 : os_cnt_q + 1'b1;
    end
  end

  // Strobe on the tick taken at count 8
  assign bit_center_o = os_tick_i & (os_cnt_q == os_center);

  // -----------------------------------------------
  // Majority filter
  // -----------------------------------------------
  // Samples at 6 and 7 are counted, sample 8 joins at the center
  assign in_window = (os_cnt_q > os_maj_init) && (os_cnt_q < os_center);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      high_cnt_q <= '0;
    end else if (os_cnt_q == os_maj_init) begin
      high_cnt_q <= '0;
    end else if (os_tick_i && in_window && rxd_sync_o) begin
      high_cnt_q <= high_cnt_q + 2'd1;
    end
  end

  // Two of three high
  assign bit_value_o = high_cnt_q[1] | (high_cnt_q[0] & rxd_sync_o);

endmodule

`default_nettype wire

//--- rx_frame_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module rx_frame_fsm (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      rxd_sync_i,
  input  logic                      bit_center_i,
  input  logic                      bit_value_i,  // Filtered level at center
  input  uart_rx_pkg::word_len_e    word_len_i,
  input  logic                      par_en_i,
  input  uart_rx_pkg::parity_mode_e par_mode_i,
  output logic                      timer_restart_o,
  output logic                      push_o,       // Stop bit center
  output uart_rx_pkg::rx_entry_t    push_entry_o
);

  uart_rx_pkg::rx_state_e state_q, state_d;

  logic [7:0] rsr_q, rsr_d;         // Receive shift register
  logic [2:0] bit_cnt_q, bit_cnt_d; // Index of next data bit
  logic       any_one_q, any_one_d; // A one seen in data or parity
  logic       par_err_q, par_err_d;
  logic [2:0] last_bit;             // Index of final data bit, 4 to 7
  logic       data_parity;

  assign last_bit    = {1'b1, word_len_i};
  assign data_parity = ^rsr_q; // Upper bits zero, safe for short words

  // -----------------------------------------------
  // Next state and datapath
  // -----------------------------------------------
  always_comb begin
    state_d         = state_q;
    rsr_d           = rsr_q;
    bit_cnt_d       = bit_cnt_q;
    any_one_d       = any_one_q;
    par_err_d       = par_err_q;
    timer_restart_o = 1'b0;
    push_o          = 1'b0;

    case (state_q)
      uart_rx_pkg::rx_idle: begin
        if (!rxd_sync_i) begin
          timer_restart_o = 1'b1; // Falling edge, start counting
          state_d         = uart_rx_pkg::rx_start;
        end
      end

      uart_rx_pkg::rx_start: begin
        if (bit_center_i) begin
          if (!bit_value_i) begin
            rsr_d     = '0;
            bit_cnt_d = '0;
            any_one_d = 1'b0;
            par_err_d = 1'b0;
            state_d   = uart_rx_pkg::rx_data;
          end else begin
            state_d = uart_rx_pkg::rx_idle; // Glitch, not a start bit
          end
        end
      end

      uart_rx_pkg::rx_data: begin
        if (bit_center_i) begin
          rsr_d[bit_cnt_q] = bit_value_i; // LSB first
          any_one_d        = any_one_q | bit_value_i;
          bit_cnt_d        = bit_cnt_q + 3'd1;
          if (bit_cnt_q == last_bit) begin
            state_d = par_en_i ? uart_rx_pkg::rx_parity : uart_rx_pkg::rx_stop;
          end
        end
      end

      uart_rx_pkg::rx_parity: begin
        if (bit_center_i) begin
          case (par_mode_i)
            uart_rx_pkg::par_odd:     par_err_d = (data_parity == bit_value_i);
            uart_rx_pkg::par_even:    par_err_d = (data_parity != bit_value_i);
            uart_rx_pkg::par_force_1: par_err_d = ~bit_value_i;
            uart_rx_pkg::par_force_0: par_err_d = bit_value_i;
            default:                  par_err_d = 1'b0;
          endcase
          any_one_d = any_one_q | bit_value_i;
          state_d   = uart_rx_pkg::rx_stop;
        end
      end

      uart_rx_pkg::rx_stop: begin
        if (bit_center_i) begin
          push_o  = 1'b1;
          // Low stop bit means lost framing
          state_d = bit_value_i ? uart_rx_pkg::rx_idle : uart_rx_pkg::rx_resync;
        end
      end

      uart_rx_pkg::rx_resync: begin
        // Line still low, treat next bit slot as a start bit
        state_d = rxd_sync_i ? uart_rx_pkg::rx_idle : uart_rx_pkg::rx_start;
      end

      default: state_d = uart_rx_pkg::rx_idle;
    endcase
  end

  // -----------------------------------------------
  // Registers
  // -----------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= uart_rx_pkg::rx_idle;
      bit_cnt_q <= '0;
    end else begin
      state_q   <= state_d;
      bit_cnt_q <= bit_cnt_d;
    end
  end

  // Character payload, loaded at start bit
  always_ff @(posedge clk_i) begin
    rsr_q     <= rsr_d;
    any_one_q <= any_one_d;
    par_err_q <= par_err_d;
  end

  // Entry built at the stop bit center
  assign push_entry_o.data       = rsr_q;
  assign push_entry_o.brk        = ~any_one_q & ~bit_value_i;
  assign push_entry_o.frame_err  = ~bit_value_i;
  assign push_entry_o.parity_err = par_err_q;

endmodule

`default_nettype wire

//--- rx_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_rx_config.svh"

module rx_fifo #(
  parameter type entry_t = logic
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            clear_i,     // Empty in one cycle
  input  logic                            push_i,
  input  entry_t                          push_data_i,
  input  logic                            pop_i,
  output entry_t                          head_o,      // Fall-through head
  output logic                            empty_o,
  output logic                            full_o,
  output logic [`UART_RX_USAGE_WIDTH-1:0] usage_o,
  output logic                            overrun_o    // Push refused
);

  localparam int unsigned depth = `UART_RX_FIFO_DEPTH;
  localparam int unsigned ptr_w = $clog2(depth);
  localparam logic [`UART_RX_USAGE_WIDTH-1:0] usage_max = `UART_RX_FIFO_DEPTH;

  entry_t                          mem_q [depth];
  logic [ptr_w-1:0]                wr_ptr_q, rd_ptr_q;
  logic [`UART_RX_USAGE_WIDTH-1:0] usage_q;
  logic                            push_ok, pop_ok;

  assign empty_o   = (usage_q == '0);
  assign full_o    = (usage_q == usage_max);
  assign usage_o   = usage_q;
  assign push_ok   = push_i & ~full_o;
  assign pop_ok    = pop_i & ~empty_o;  // Pop on empty ignored
  assign overrun_o = push_i & full_o;   // Character lost
  assign head_o    = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_ok) mem_q[wr_ptr_q] <= push_data_i;
  end

  // -----------------------------------------------
  // Pointers and usage count
  // -----------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (push_ok) wr_ptr_q <= wr_ptr_q + 1'b1; // Wraps at depth
      if (pop_ok) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   usage_q <= usage_q + 1'b1;
        2'b01:   usage_q <= usage_q - 1'b1;
        default: usage_q <= usage_q; // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rx_fifo_monitor.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_rx_config.svh"

module rx_fifo_monitor (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            baud_tick_i,
  input  uart_rx_pkg::fifo_tl_e           tl_i,
  input  logic [`UART_RX_USAGE_WIDTH-1:0] usage_i,
  input  logic                            activity_i, // Push, pop or clear
  output logic                            trigger_o,
  output logic                            timeout_o
);

  localparam int unsigned to_w = $clog2(`UART_RX_TIMEOUT_BAUDS + 1);
  localparam logic [to_w-1:0] to_last = `UART_RX_TIMEOUT_BAUDS - 1;

  logic [`UART_RX_USAGE_WIDTH-1:0] tl_chars;  // Level in characters
  logic [to_w-1:0]                 to_cnt_q;  // Baud ticks since activity

  // -----------------------------------------------
  // Trigger level
  // -----------------------------------------------
  always_comb begin
    case (tl_i)
      uart_rx_pkg::tl_1:  tl_chars = 5'd1;
      uart_rx_pkg::tl_4:  tl_chars = 5'd4;
      uart_rx_pkg::tl_8:  tl_chars = 5'd8;
      uart_rx_pkg::tl_14: tl_chars = 5'd14;
      default:            tl_chars = 5'd1;
    endcase
  end

  assign trigger_o = (usage_i >= tl_chars);

  // -----------------------------------------------
  // Character timeout
  // -----------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      to_cnt_q  <= '0;
      timeout_o <= 1'b0;
    end else begin
      timeout_o <= 1'b0;
      if (activity_i || usage_i == '0) begin
        to_cnt_q <= '0; // Held while empty
      end else if (baud_tick_i) begin
        if (to_cnt_q == to_last) begin
          to_cnt_q  <= '0; // Restart for next pulse
          timeout_o <= 1'b1;
        end else begin
          to_cnt_q <= to_cnt_q + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- uart_rx_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_rx_config.svh"

module uart_rx_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      os_tick_i,    // 16x baud strobe
  input  logic                      baud_tick_i,  // Baud strobe for timeout
  input  logic                      rxd_i,
  input  uart_rx_pkg::word_len_e    word_len_i,
  input  logic                      par_en_i,
  input  uart_rx_pkg::parity_mode_e par_mode_i,
  input  uart_rx_pkg::fifo_tl_e     fifo_tl_i,
  input  logic                      fifo_clear_i,
  input  logic                      rd_i,         // Pop strobe
  output uart_rx_pkg::rx_entry_t    rd_entry_o,
  output logic                      rd_empty_o,
  output logic                      overrun_o,
  output logic                      trigger_o,
  output logic                      timeout_o
);

  // -----------------------------------------------
  // Internal nets
  // -----------------------------------------------
  logic                            rxd_sync;
  logic                            bit_center;
  logic                            bit_value;
  logic                            timer_restart;
  logic                            push;
  uart_rx_pkg::rx_entry_t          push_entry;
  logic [`UART_RX_USAGE_WIDTH-1:0] fifo_usage;
  logic                            fifo_activity;

  assign fifo_activity = push | rd_i | fifo_clear_i; // Restarts timeout

  rx_bit_sampler u_rx_bit_sampler (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .os_tick_i       (os_tick_i),
    .rxd_i           (rxd_i),
    .timer_restart_i (timer_restart),
    .rxd_sync_o      (rxd_sync),
    .bit_center_o    (bit_center),
    .bit_value_o     (bit_value)
  );

  rx_frame_fsm u_rx_frame_fsm (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .rxd_sync_i      (rxd_sync),
    .bit_center_i    (bit_center),
    .bit_value_i     (bit_value),
    .word_len_i      (word_len_i),
    .par_en_i        (par_en_i),
    .par_mode_i      (par_mode_i),
    .timer_restart_o (timer_restart),
    .push_o          (push),
    .push_entry_o    (push_entry)
  );

  rx_fifo #(
    .entry_t (uart_rx_pkg::rx_entry_t)
  ) u_rx_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .clear_i     (fifo_clear_i),
    .push_i      (push),
    .push_data_i (push_entry),
    .pop_i       (rd_i),
    .head_o      (rd_entry_o),
    .empty_o     (rd_empty_o),
    .full_o      (),           // Seen only through overrun
    .usage_o     (fifo_usage),
    .overrun_o   (overrun_o)
  );

  rx_fifo_monitor u_rx_fifo_monitor (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .baud_tick_i (baud_tick_i),
    .tl_i        (fifo_tl_i),
    .usage_i     (fifo_usage),
    .activity_i  (fifo_activity),
    .trigger_o   (trigger_o),
    .timeout_o   (timeout_o)
  );

endmodule

`default_nettype wire

//--- tb_uart_rx_tasks.svh
`ifndef TB_UART_RX_TASKS_SVH
`define TB_UART_RX_TASKS_SVH

// Parity bit that satisfies the selected mode
function automatic logic correct_parity_bit(input logic [7:0] data, input int mode);
  case (mode)
    0:       return ~(^data); // Odd count of ones overall
    1:       return ^data;    // Even count of ones overall
    2:       return 1'b1;
    default: return 1'b0;
  endcase
endfunction

// Character count for a trigger level code
function automatic int level_chars(input int code);
  case (code)
    0:       return 1;
    1:       return 4;
    2:       return 8;
    default: return 14;
  endcase
endfunction

// One bit slot of 32 clocks, optional 2-clock glitch mid-bit
task automatic hold_bit(input logic value, input bit glitch);
  for (int i = 0; i < 32; i++) begin
    @(negedge clk);
    rxd = (glitch && (i == 15 || i == 16)) ? ~value : value;
  end
endtask

// Start, data LSB first, optional parity, stop, one idle bit
task automatic send_frame(input logic [7:0] data, input int nbits, input bit has_par,
                          input logic par_bit, input logic stop_bit, input int glitch_idx);
  hold_bit(1'b0, 1'b0);
  for (int i = 0; i < nbits; i++) hold_bit(data[i], i == glitch_idx);
  if (has_par) hold_bit(par_bit, 1'b0);
  hold_bit(stop_bit, 1'b0);
  hold_bit(1'b1, 1'b0); // Idle gap
endtask

`endif

//--- tb_uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module tb_uart_rx;

  localparam int watchdog_cycles = 30000; // About 19k clocks of frames plus margin

  logic clk;
  logic rst_n;
  logic os_tick;
  logic baud_tick;
  logic rxd;
  uart_rx_pkg::word_len_e    word_len;
  logic                      par_en;
  uart_rx_pkg::parity_mode_e par_mode;
  uart_rx_pkg::fifo_tl_e     fifo_tl;
  logic                      fifo_clear;
  logic                      rd;
  uart_rx_pkg::rx_entry_t    rd_entry;
  logic                      rd_empty;
  logic                      overrun;
  logic                      trigger;
  logic                      timeout;

  int seed = 46203;
  int errors = 0;
  int checks = 0;
  int errors_at_start = 0;
  int cycles = 0;
  int baud_seen = 0;    // Baud ticks consumed by the DUT
  int overrun_cnt = 0;
  int timeout_cnt = 0;
  int tick_cnt;

  `include "tb_uart_rx_tasks.svh"

  uart_rx_top u_uart_rx_top (
    .clk_i(clk), .rst_n_i(rst_n), .os_tick_i(os_tick), .baud_tick_i(baud_tick),
    .rxd_i(rxd), .word_len_i(word_len), .par_en_i(par_en), .par_mode_i(par_mode),
    .fifo_tl_i(fifo_tl), .fifo_clear_i(fifo_clear), .rd_i(rd),
    .rd_entry_o(rd_entry), .rd_empty_o(rd_empty), .overrun_o(overrun),
    .trigger_o(trigger), .timeout_o(timeout)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------------------
  // Oversample strobe every 2 clocks and baud strobe every 32 clocks
  // ----------------------------------------------------
  initial begin
    os_tick   = 1'b0;
    baud_tick = 1'b0;
    tick_cnt  = 0;
    forever begin
      @(negedge clk);
      tick_cnt++;
      os_tick   = tick_cnt[0];
      baud_tick = (tick_cnt[4:0] == 5'd0);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (baud_tick) baud_seen++;
    if (overrun) overrun_cnt++;
    if (timeout) timeout_cnt++;
    if (cycles >= watchdog_cycles) begin
      $display("Run stopped: watchdog limit of %0d cycles reached", watchdog_cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // No timeout pulse while the FIFO is empty
  timeout_empty_chk: assert property (@(posedge clk) disable iff (!rst_n) rd_empty |-> !timeout)
    else begin
      errors++;
      $display("FAILED at %0t: timeout pulse with empty FIFO", $time);
    end
  // Overrun lasts a single cycle
  overrun_pulse_chk: assert property (@(posedge clk) disable iff (!rst_n) overrun |=> !overrun)
    else begin
      errors++;
      $display("FAILED at %0t: overrun held longer than one cycle", $time);
    end

  task automatic expect_eq(input int got, input int exp, input string what);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("FAILED at %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s done, %0d errors", name, errors - errors_at_start);
    errors_at_start = errors;
  endtask

  // Wait for a character and pop the head
  task automatic pop_entry(output uart_rx_pkg::rx_entry_t e);
    int waited;
    waited = 0;
    while (rd_empty && waited < 2000) begin
      @(negedge clk);
      waited++;
    end
    if (rd_empty) begin
      errors++;
      $display("No character arrived in the FIFO within 2000 cycles");
      e = '0;
    end else begin
      e  = rd_entry;
      rd = 1'b1;
      @(negedge clk);
      rd = 1'b0;
    end
  endtask

  // Send one frame and compare the entry with the expected fields
  task automatic rx_and_check(input logic [7:0] data, input int nbits, input bit has_par,
                              input logic par_bit, input logic stop_bit, input int glitch);
    uart_rx_pkg::rx_entry_t e;
    logic [7:0] masked;
    logic       pe_exp;
    logic       brk_exp;
    masked  = data & 8'((1 << nbits) - 1);
    pe_exp  = has_par && (par_bit != correct_parity_bit(masked, int'(par_mode)));
    brk_exp = (masked == 8'd0) && !(has_par && par_bit) && !stop_bit;
    word_len = uart_rx_pkg::word_len_e'(nbits - 5);
    par_en   = has_par;
    send_frame(data, nbits, has_par, par_bit, stop_bit, glitch);
    pop_entry(e);
    expect_eq(e.data, masked, "data");
    expect_eq(e.parity_err, pe_exp, "parity_err");
    expect_eq(e.frame_err, !stop_bit, "frame_err");
    expect_eq(e.brk, brk_exp, "brk");
  endtask

  task automatic pulse_clear();
    fifo_clear = 1'b1;
    @(negedge clk);
    fifo_clear = 1'b0;
    @(negedge clk);
  endtask

  initial begin
    uart_rx_pkg::rx_entry_t e;
    logic [7:0] d;
    logic [7:0] sent [$];
    int start_ticks;
    int waited;
    rst_n = 1'b0;
    rxd = 1'b1;
    word_len = uart_rx_pkg::wl_8;
    par_en = 1'b0;
    par_mode = uart_rx_pkg::par_odd;
    fifo_tl = uart_rx_pkg::tl_1;
    fifo_clear = 1'b0;
    rd = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);
    expect_eq(rd_empty, 1, "empty after reset");

    // Character reception ---------------------------------
    for (int n = 5; n <= 8; n++) begin
      for (int k = 0; k < 3; k++) rx_and_check(8'($random(seed)), n, 0, 0, 1, -1);
    end
    rx_and_check(8'hA5, 8, 0, 0, 1, 2); // Glitch on data bit 2
    end_test("reception");

    // Parity with a correct then a wrong bit per mode
    for (int m = 0; m < 4; m++) begin
      par_mode = uart_rx_pkg::parity_mode_e'(m);
      d = 8'($random(seed));
      rx_and_check(d, 8, 1, correct_parity_bit(d, m), 1, -1);
      rx_and_check(d, 8, 1, ~correct_parity_bit(d, m), 1, -1);
    end
    end_test("parity");

    rx_and_check(8'h5A, 8, 0, 0, 0, -1); // Low stop bit
    rx_and_check(8'h00, 8, 0, 0, 0, -1); // Break
    rx_and_check(8'hC3, 8, 0, 0, 1, -1);
    end_test("framing");

    // Trigger levels ---------------------------------------
    pulse_clear();
    for (int k = 1; k <= 14; k++) begin
      word_len = uart_rx_pkg::wl_5;
      send_frame(8'($random(seed)), 5, 0, 0, 1, -1);
      for (int lv = 0; lv < 4; lv++) begin
        fifo_tl = uart_rx_pkg::fifo_tl_e'(lv);
        @(negedge clk);
        expect_eq(trigger, k >= level_chars(lv), "trigger while filling");
      end
    end
    pop_entry(e);
    expect_eq(trigger, 0, "trigger at 13 of 14");
    fifo_tl = uart_rx_pkg::tl_8;
    @(negedge clk);
    expect_eq(trigger, 1, "trigger at 13 of 8");
    repeat (6) pop_entry(e);
    expect_eq(trigger, 0, "trigger at 7 of 8");
    fifo_tl = uart_rx_pkg::tl_1;
    @(negedge clk);
    expect_eq(trigger, 1, "trigger at 7 of 1");
    pulse_clear();
    expect_eq(trigger, 0, "trigger after clear");
    end_test("trigger");

    // Overrun from 17 characters into 16 entries
    overrun_cnt = 0;
    word_len = uart_rx_pkg::wl_5;
    for (int k = 0; k < 17; k++) begin
      d = 8'($random(seed)) & 8'h1F;
      sent.push_back(d);
      send_frame(d, 5, 0, 0, 1, -1);
    end
    expect_eq(overrun_cnt, 1, "overrun pulses");
    for (int k = 0; k < 16; k++) begin
      pop_entry(e);
      expect_eq(e.data, sent[k], "overrun read order");
    end
    expect_eq(rd_empty, 1, "empty after draining");
    end_test("overrun");

    // Timeout ---------------------------------------------
    timeout_cnt = 0;
    repeat (60 * 32) @(negedge clk);
    expect_eq(timeout_cnt, 0, "timeouts while empty");
    fork
      send_frame(8'h3C, 5, 0, 0, 1, -1);
      begin
        waited = 0;
        while (rd_empty && waited < 1000) begin
          @(negedge clk);
          waited++;
        end
        start_ticks = baud_seen;
        while (!timeout && waited < 3000) begin
          @(negedge clk);
          waited++;
        end
      end
    join
    if (!timeout) begin
      errors++;
      $display("Timeout never pulsed with one character left unread");
    end else begin
      checks++;
      assert ((baud_seen - start_ticks) inside {48, 49}) else begin
        errors++;
        $display("FAILED at %0t: timeout after %0d baud ticks", $time,
                 baud_seen - start_ticks);
      end
      @(negedge clk);
      expect_eq(timeout, 0, "timeout pulse width");
    end
    pop_entry(e);
    expect_eq(e.data, 8'h1C, "timeout character");
    end_test("timeout");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
uart_rx_pkg.sv
rx_bit_sampler.sv
rx_frame_fsm.sv
rx_fifo.sv
rx_fifo_monitor.sv
uart_rx_top.sv
tb_uart_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the UART receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
  -f all.f --top-module tb_uart_rx --Mdir obj_dir -o sim_tb_uart_rx
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_uart_rx > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error"
  cat sim.log
  exit 1
fi

cat sim.log
if grep -q "^TESTBENCH PASSED$" sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi
